/* hdl/div_uart_pkg.sv */
package div_uart_pkg;

   localparam int BYTE_W   = 8;
   localparam int NIBBLE_W = 4;

   // Host command opcodes in the low nibble of each received byte
   typedef enum logic [NIBBLE_W-1:0] {
      OP_LOAD_DIVIDEND = 4'd0,
      OP_LOAD_DIVISOR  = 4'd1,
      OP_READ_QUOT     = 4'd2,
      OP_READ_REM      = 4'd3,
      OP_DIVIDE        = 4'd4
   } cmd_op_e;

   typedef struct packed {
      logic [NIBBLE_W-1:0] data;  // Operand nibble shifted in by the load opcodes
      cmd_op_e             op;
   } cmd_t;

endpackage

/* hdl/uart_rx.sv */
module uart_rx import div_uart_pkg::*; #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_rx,
   output logic o_valid,
   output cmd_t o_cmd
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam int BIT_W = $clog2(BYTE_W);
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
   localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(BYTE_W - 1);

   typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} state_e;

   logic [2:0]        rx_sync;
   logic              rx_s;
   logic              rx_prev;
   state_e            state;
   logic [CNT_W-1:0]  clk_cnt;
   logic [BIT_W-1:0]  bit_cnt;
   logic [BYTE_W-1:0] shreg;

   assign rx_s  = rx_sync[2];
   assign o_cmd = cmd_t'(shreg);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= '1;  // Idle line level
         rx_prev <= 1'b1;
      end else begin
         rx_sync <= {rx_sync[1:0], i_rx};
         rx_prev <= rx_s;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= ST_IDLE;
         clk_cnt <= '0;
         bit_cnt <= '0;
         o_valid <= 1'b0;
      end else begin
         o_valid <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (rx_prev && !rx_s) begin
                  state   <= ST_START;
                  clk_cnt <= '0;
               end
            end
            ST_START: begin
               if (clk_cnt == HALF_CNT) begin
                  clk_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= rx_s ? ST_IDLE : ST_DATA;  // A high line here was only a glitch
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            ST_DATA: begin
               if (clk_cnt == LAST_CNT) begin
                  clk_cnt <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == LAST_BIT) state <= ST_STOP;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            ST_STOP: begin
               if (clk_cnt == LAST_CNT) begin
                  state   <= ST_IDLE;
                  o_valid <= rx_s;  // Framing error drops the byte
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == ST_DATA && clk_cnt == LAST_CNT) begin
         shreg <= {rx_s, shreg[BYTE_W-1:1]};  // LSB arrives first
      end
   end

endmodule

/* hdl/uart_tx.sv */
module uart_tx import div_uart_pkg::*; #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic              i_clk,
   input  logic              i_nrst,
   input  logic              i_valid,
   input  logic [BYTE_W-1:0] i_byte,
   output logic              o_ready,
   output logic              o_tx
);

   localparam int FRAME_BITS = BYTE_W + 2;
   localparam int FRAME_CLKS = FRAME_BITS * CLKS_PER_BIT;
   localparam int CNT_W      = $clog2(CLKS_PER_BIT);
   localparam int BIT_W      = $clog2(FRAME_BITS);
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(FRAME_BITS - 1);

   logic              busy;
   logic              start;
   logic [CNT_W-1:0]  clk_cnt;
   logic [BIT_W-1:0]  bit_cnt;
   logic [BYTE_W:0]   shreg;  // Data bits followed by the stop bit

   assign o_ready = !busy;
   assign start   = i_valid && !busy;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy    <= 1'b0;
         clk_cnt <= '0;
         bit_cnt <= '0;
         o_tx    <= 1'b1;
      end else if (start) begin
         busy    <= 1'b1;
         clk_cnt <= '0;
         bit_cnt <= '0;
         o_tx    <= 1'b0;  // Start bit
      end else if (busy) begin
         if (clk_cnt == LAST_CNT) begin
            clk_cnt <= '0;
            if (bit_cnt == LAST_BIT) begin
               busy <= 1'b0;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
               o_tx    <= shreg[0];
            end
         end else begin
            clk_cnt <= clk_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (start) begin
         shreg <= {1'b1, i_byte};
      end else if (busy && clk_cnt == LAST_CNT) begin
         shreg <= {1'b1, shreg[BYTE_W:1]};
      end
   end

   a_frame_busy : assert property (@(posedge i_clk) disable iff (!i_nrst)
      start |=> !o_ready [*FRAME_CLKS] ##1 o_ready);

endmodule

/* hdl/seq_divider.sv */
module seq_divider #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_valid,
   input  logic [DATA_WIDTH-1:0] i_dividend,
   input  logic [DATA_WIDTH-1:0] i_divisor,
   output logic                  o_accept,
   output logic [DATA_WIDTH-1:0] o_quotient,
   output logic [DATA_WIDTH-1:0] o_remainder
);

   localparam int CNT_W = $clog2(DATA_WIDTH);
   localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(DATA_WIDTH - 1);

   typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_DONE} state_e;

   state_e                state;
   logic [CNT_W-1:0]      iter_cnt;
   logic [DATA_WIDTH-1:0] divisor_q;
   logic [DATA_WIDTH-1:0] rem_q;
   logic [DATA_WIDTH-1:0] quo_q;  // Dividend bits leave at the top, quotient bits enter at the bottom
   logic [DATA_WIDTH:0]   partial;
   logic [DATA_WIDTH+1:0] diff;
   logic                  fits;

   assign partial = {rem_q, quo_q[DATA_WIDTH-1]};
   assign diff    = {1'b0, partial} - {2'b00, divisor_q};
   assign fits    = !diff[DATA_WIDTH+1];  // No borrow so the divisor goes in

   assign o_accept    = (state == ST_DONE);
   assign o_quotient  = quo_q;
   assign o_remainder = rem_q;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= ST_IDLE;
         iter_cnt <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_valid) begin
                  state    <= ST_BUSY;
                  iter_cnt <= '0;
               end
            end
            ST_BUSY: begin
               if (iter_cnt == LAST_ITER) begin
                  state <= ST_DONE;
               end else begin
                  iter_cnt <= iter_cnt + 1'b1;
               end
            end
            ST_DONE: state <= ST_IDLE;  // Requester drops valid during this cycle
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == ST_IDLE && i_valid) begin
         divisor_q <= i_divisor;
         quo_q     <= i_dividend;
         rem_q     <= '0;
      end else if (state == ST_BUSY) begin
         // A zero divisor always fits, giving all ones and the dividend back
         rem_q <= fits ? diff[DATA_WIDTH-1:0] : partial[DATA_WIDTH-1:0];
         quo_q <= {quo_q[DATA_WIDTH-2:0], fits};
      end
   end

   a_operands_stable : assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_valid && state != ST_IDLE) |-> ($stable(i_dividend) && $stable(i_divisor)));

endmodule

/* hdl/div_cmd_ctrl.sv */
module div_cmd_ctrl import div_uart_pkg::*; #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_rx_valid,
   input  cmd_t                  i_rx_cmd,
   output logic                  o_div_valid,
   output logic [DATA_WIDTH-1:0] o_dividend,
   output logic [DATA_WIDTH-1:0] o_divisor,
   input  logic                  i_div_accept,
   input  logic [DATA_WIDTH-1:0] i_quotient,
   input  logic [DATA_WIDTH-1:0] i_remainder,
   output logic                  o_tx_valid,
   output logic [BYTE_W-1:0]     o_tx_byte,
   input  logic                  i_tx_ready
);

   typedef enum logic [1:0] {ST_IDLE, ST_DIVIDING, ST_SENDING} state_e;

   state_e                state;
   logic [DATA_WIDTH-1:0] dividend_q;
   logic [DATA_WIDTH-1:0] divisor_q;
   logic [DATA_WIDTH-1:0] quot_q;
   logic [DATA_WIDTH-1:0] rem_q;
   logic [BYTE_W-1:0]     tx_byte_q;

   if (DATA_WIDTH % BYTE_W != 0) begin : g_width_check
      $error("DATA_WIDTH must be a multiple of %0d", BYTE_W);
   end

   assign o_div_valid = (state == ST_DIVIDING);
   assign o_tx_valid  = (state == ST_SENDING);
   assign o_dividend  = dividend_q;
   assign o_divisor   = divisor_q;
   assign o_tx_byte   = tx_byte_q;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= ST_IDLE;
         dividend_q <= '0;
         divisor_q  <= '0;
         quot_q     <= '0;
         rem_q      <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_rx_valid) begin
                  case (i_rx_cmd.op)
                     OP_LOAD_DIVIDEND: begin
                        dividend_q <= {dividend_q[DATA_WIDTH-NIBBLE_W-1:0], i_rx_cmd.data};
                     end
                     OP_LOAD_DIVISOR: begin
                        divisor_q <= {divisor_q[DATA_WIDTH-NIBBLE_W-1:0], i_rx_cmd.data};
                     end
                     OP_READ_QUOT: begin
                        quot_q <= quot_q >> BYTE_W;
                        state  <= ST_SENDING;
                     end
                     OP_READ_REM: begin
                        rem_q <= rem_q >> BYTE_W;
                        state <= ST_SENDING;
                     end
                     OP_DIVIDE: state <= ST_DIVIDING;
                     default: ;  // Unused opcodes leave all state alone
                  endcase
               end
            end
            ST_DIVIDING: begin
               if (i_div_accept) begin
                  quot_q <= i_quotient;
                  rem_q  <= i_remainder;
                  state  <= ST_IDLE;
               end
            end
            ST_SENDING: begin
               if (i_tx_ready) state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == ST_IDLE && i_rx_valid) begin
         if (i_rx_cmd.op == OP_READ_QUOT) begin
            tx_byte_q <= quot_q[BYTE_W-1:0];
         end else if (i_rx_cmd.op == OP_READ_REM) begin
            tx_byte_q <= rem_q[BYTE_W-1:0];
         end
      end
   end

   // The divider may only finish a division that was requested
   a_accept_requested : assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_div_accept |-> o_div_valid);

endmodule

/* hdl/div_uart_top.sv */
module div_uart_top import div_uart_pkg::*; #(
   parameter int DATA_WIDTH   = 32,
   parameter int CLKS_PER_BIT = 16
) (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_rx,
   output logic o_tx
);

   logic                  rx_valid;
   cmd_t                  rx_cmd;
   logic                  div_valid;
   logic                  div_accept;
   logic [DATA_WIDTH-1:0] dividend;
   logic [DATA_WIDTH-1:0] divisor;
   logic [DATA_WIDTH-1:0] quotient;
   logic [DATA_WIDTH-1:0] remainder;
   logic                  tx_valid;
   logic                  tx_ready;
   logic [BYTE_W-1:0]     tx_byte;

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_uart_rx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_rx    (i_rx),
      .o_valid (rx_valid),
      .o_cmd   (rx_cmd)
   );

   div_cmd_ctrl #(
      .DATA_WIDTH (DATA_WIDTH)
   ) u_ctrl (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_rx_valid   (rx_valid),
      .i_rx_cmd     (rx_cmd),
      .o_div_valid  (div_valid),
      .o_dividend   (dividend),
      .o_divisor    (divisor),
      .i_div_accept (div_accept),
      .i_quotient   (quotient),
      .i_remainder  (remainder),
      .o_tx_valid   (tx_valid),
      .o_tx_byte    (tx_byte),
      .i_tx_ready   (tx_ready)
   );

   seq_divider #(
      .DATA_WIDTH (DATA_WIDTH)
   ) u_divider (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_valid     (div_valid),
      .i_dividend  (dividend),
      .i_divisor   (divisor),
      .o_accept    (div_accept),
      .o_quotient  (quotient),
      .o_remainder (remainder)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_uart_tx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_valid (tx_valid),
      .i_byte  (tx_byte),
      .o_ready (tx_ready),
      .o_tx    (o_tx)
   );

endmodule

/* dv/tb_clkgen.sv */
module tb_clkgen #(
   parameter int RESET_CYCLES = 3
) (
   output logic o_clk,
   output logic o_nrst
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      o_clk  = 1'b0;
      o_nrst = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      #1 o_nrst = 1'b1;  // Release just after an edge
   end

   always #5 o_clk = ~o_clk;  // 10 ns period

endmodule

/* dv/tb_div_uart.sv */
module tb_div_uart import div_uart_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DATA_WIDTH   = 32;
   localparam int CLKS_PER_BIT = 16;
   localparam int N_PAIRS      = 60;
   localparam int NIBBLES      = DATA_WIDTH / NIBBLE_W;
   localparam int READS        = DATA_WIDTH / BYTE_W;
   localparam int CMDS_PER_DIV = 2 * NIBBLES + 1 + 2 * READS;
   // Reset reads, random pairs, zero divisor, long loads, unused opcodes
   localparam int N_CMDS = 2 * READS + N_PAIRS * CMDS_PER_DIV + CMDS_PER_DIV
                         + (CMDS_PER_DIV + 7) + (CMDS_PER_DIV + NIBBLES + 2);
   localparam int TIMEOUT_NS = N_CMDS * 25 * CLKS_PER_BIT * 10 + 100000;

   logic clk;
   logic nrst;
   logic rx;
   logic tx;
   int   seed = 32'h2fdf9baa;
   int   n_errors = 0;
   int   n_checks = 0;

   logic [DATA_WIDTH-1:0] m_dividend;  // Reference model registers
   logic [DATA_WIDTH-1:0] m_divisor;
   logic [DATA_WIDTH-1:0] m_quot;
   logic [DATA_WIDTH-1:0] m_rem;

   tb_clkgen u_clkgen (
      .o_clk  (clk),
      .o_nrst (nrst)
   );

   div_uart_top #(
      .DATA_WIDTH   (DATA_WIDTH),
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) dut0 (
      .i_clk  (clk),
      .i_nrst (nrst),
      .i_rx   (rx),
      .o_tx   (tx)
   );

   task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic finish_run;
      $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   endtask

   function automatic cmd_t make_cmd(input logic [3:0] op_nib, input logic [3:0] nib);
      cmd_t c;
      c.data = nib;
      c.op   = cmd_op_e'(op_nib);
      return c;
   endfunction

   task automatic send_byte(input logic [BYTE_W-1:0] data, input logic stop_bit);
      logic [BYTE_W+1:0] frame;
      frame = {stop_bit, data, 1'b0};  // Start bit goes out first
      for (int i = 0; i < BYTE_W + 2; i++) begin
         @(posedge clk);
         #1 rx = frame[i];
         repeat (CLKS_PER_BIT - 1) @(posedge clk);
      end
      @(posedge clk);
      #1 rx = 1'b1;  // One idle bit before the next frame
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
   endtask

   task automatic recv_byte(output logic [BYTE_W-1:0] data);
      logic [BYTE_W-1:0] bits;
      @(negedge tx);
      repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Middle of the start bit
      if (tx !== 1'b0) begin
         n_errors++;
         $display("Start bit on o_tx did not stay low at %0t", $time);
      end
      for (int i = 0; i < BYTE_W; i++) begin
         repeat (CLKS_PER_BIT) @(negedge clk);
         bits[i] = tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (tx !== 1'b1) begin
         n_errors++;
         $display("Stop bit on o_tx was not high at %0t", $time);
      end
      data = bits;
   endtask

   task automatic model_divide;
      if (m_divisor != '0) begin
         m_quot = m_dividend / m_divisor;
         m_rem  = m_dividend % m_divisor;
      end else begin
         m_quot = '1;
         m_rem  = m_dividend;
      end
   endtask

   // Sends one command and applies it to the model
   task automatic send_cmd(input logic [3:0] op_nib, input logic [3:0] nib);
      send_byte(make_cmd(op_nib, nib), 1'b1);
      case (op_nib)
         OP_LOAD_DIVIDEND: m_dividend = {m_dividend[DATA_WIDTH-NIBBLE_W-1:0], nib};
         OP_LOAD_DIVISOR:  m_divisor  = {m_divisor[DATA_WIDTH-NIBBLE_W-1:0], nib};
         OP_DIVIDE: begin
            model_divide();
            repeat (4 * DATA_WIDTH) @(posedge clk);  // No done signal reaches the pins
         end
         default: ;
      endcase
   endtask

   task automatic read_byte(input cmd_op_e op);
      logic [BYTE_W-1:0] got;
      logic [BYTE_W-1:0] exp;
      fork
         send_byte(make_cmd(op, 4'h0), 1'b1);
         recv_byte(got);
      join
      if (op == OP_READ_QUOT) begin
         exp    = m_quot[BYTE_W-1:0];
         m_quot = m_quot >> BYTE_W;
         check_value("quotient byte", DATA_WIDTH'(got), DATA_WIDTH'(exp));
      end else begin
         exp   = m_rem[BYTE_W-1:0];
         m_rem = m_rem >> BYTE_W;
         check_value("remainder byte", DATA_WIDTH'(got), DATA_WIDTH'(exp));
      end
   endtask

   task automatic read_result(input cmd_op_e op, input int n);
      repeat (n) read_byte(op);
   endtask

   task automatic load_operand(input logic [3:0] op_nib, input logic [63:0] value, input int n);
      for (int i = n - 1; i >= 0; i--) begin
         send_cmd(op_nib, value[i*NIBBLE_W +: NIBBLE_W]);  // Most significant nibble first
      end
   endtask

   task automatic load_with_junk(input logic [3:0] op_nib, input logic [DATA_WIDTH-1:0] value);
      logic [3:0] junk;
      for (int i = NIBBLES - 1; i >= 0; i--) begin
         send_cmd(op_nib, value[i*NIBBLE_W +: NIBBLE_W]);
         if (i % 2 == 0) begin
            junk = 4'(5 + $unsigned($random(seed)) % 11);
            send_cmd(junk, 4'($random(seed)));
         end
      end
   endtask

   task automatic run_division(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
      load_operand(OP_LOAD_DIVIDEND, 64'(a), NIBBLES);
      load_operand(OP_LOAD_DIVISOR, 64'(b), NIBBLES);
      send_cmd(OP_DIVIDE, 4'h0);
      read_result(OP_READ_QUOT, READS);
      read_result(OP_READ_REM, READS);
   endtask

   initial begin
      logic [DATA_WIDTH-1:0] a;
      logic [DATA_WIDTH-1:0] b;
      logic                  tx_min;
      rx         = 1'b1;
      m_dividend = '0;
      m_divisor  = '0;
      m_quot     = '0;
      m_rem      = '0;
      @(posedge nrst);

      tx_min = 1'b1;
      repeat (4 * CLKS_PER_BIT) begin
         @(negedge clk);
         tx_min = tx_min & tx;
      end
      check_value("o_tx after reset", DATA_WIDTH'(tx_min), 1);
      read_result(OP_READ_QUOT, READS);
      read_result(OP_READ_REM, READS);

      for (int k = 0; k < N_PAIRS; k++) begin
         a = $random(seed);
         b = $random(seed);
         case ($unsigned($random(seed)) % 4)
            0: b = b & 32'h0000_00ff;
            1: b = b & 32'h0000_ffff;
            default: ;
         endcase
         if (b == '0) b = 1;
         run_division(a, b);
      end

      run_division($random(seed), '0);

      // Only the last eight nibbles of each load survive
      load_operand(OP_LOAD_DIVIDEND, {$random(seed), $random(seed)}, NIBBLES + 2);
      b = ($random(seed) & 32'h000f_ffff) | 32'h1;
      load_operand(OP_LOAD_DIVISOR, {28'h0, 4'hf, b}, NIBBLES + 1);
      send_cmd(OP_DIVIDE, 4'h0);
      read_result(OP_READ_QUOT, READS + 2);
      read_result(OP_READ_REM, READS + 2);

      load_with_junk(OP_LOAD_DIVIDEND, $random(seed));
      send_byte(make_cmd(OP_LOAD_DIVIDEND, 4'hf), 1'b0);  // Low stop bit so the DUT drops it
      b = ($random(seed) & 32'h00ff_ffff) | 32'h1;
      load_with_junk(OP_LOAD_DIVISOR, b);
      send_cmd(OP_DIVIDE, 4'h0);
      send_cmd(4'hb, 4'h3);
      read_result(OP_READ_QUOT, READS);
      read_result(OP_READ_REM, READS);

      finish_run();
   end

   initial begin
      #(TIMEOUT_NS);
      n_errors++;
      $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      finish_run();
   end

endmodule

/* all.f */
hdl/div_uart_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/seq_divider.sv
hdl/div_cmd_ctrl.sv
hdl/div_uart_top.sv
dv/tb_clkgen.sv
dv/tb_div_uart.sv

/* run.sh */
#!/bin/sh
# Builds and runs the divider UART regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_div_uart \
   --Mdir obj_dir -o tb_div_uart \
   -f all.f

./obj_dir/tb_div_uart | tee sim.log

if grep -q "Regression passed" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
